/* list.f */
+incdir+logic
logic/x86_decode_pkg.sv
logic/prefix_strip.sv
logic/opcode_table.sv
logic/gpr_file.sv
logic/decode_opnds.sv
logic/x86_decode_top.sv
verification/x86_decode_tb.sv

/* logic/decode_opnds.sv */
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_config.svh"

module decode_opnds (
  input  wire x86_decode_pkg::stage1_t   stage,
  input  wire x86_decode_pkg::gpr_bank_t bank,
  output x86_decode_pkg::opnd_result_t   result
);

  x86_decode_pkg::opnd_form_e  form;
  x86_decode_pkg::modrm_imm_u  byte1;
  x86_decode_pkg::modrm_t      modrm;
  x86_decode_pkg::opnd_kind_e  kind0, kind1, kind2;
  logic [`X86_RAW_W-17:0]      instr;
  logic [`X86_RAW_W-17:0]      imm_shift;
  logic [`X86_NUM_REGS-1:0][31:0] regs;
  logic [2:0]  sel0, sel1;
  logic [2:0]  imm_off;
  logic [31:0] imm_window, imm;
  logic has_imm, has_modrm, rm_direct, has_sib, disp_1byte, disp_4byte;
  logic opnd0_modrm_rm, opnd0_modrm_reg, opnd1_modrm_rm, opnd1_modrm_reg;
  logic opnd0_opcode, opnd0_eax;

  function automatic logic [31:0] size_reg(input logic [31:0] value, input logic byte_op,
                                           input logic word_op);
    if (byte_op) return {24'd0, value[7:0]};
    if (word_op) return {16'd0, value[15:0]};
    return value;
  endfunction

  function automatic logic [31:0] pick(input x86_decode_pkg::opnd_kind_e kind,
                                       input logic [31:0] regval, input logic [31:0] immval);
    case (kind)
      x86_decode_pkg::KIND_REG: return regval;
      x86_decode_pkg::KIND_IMM: return immval;
      // Memory operands carry no value yet
      default:                  return 32'd0;
    endcase
  endfunction

  assign instr = stage.unescaped;
  assign form  = stage.entry.known ? stage.entry.form : x86_decode_pkg::FORM_NONE;
  // Bank viewed as an array indexed by register number
  assign regs  = bank;

  assign has_imm = form == x86_decode_pkg::FORM_IMM || form == x86_decode_pkg::FORM_REG_IMM ||
                   form == x86_decode_pkg::FORM_EAX_IMM ||
                   form == x86_decode_pkg::FORM_MODRM_RM_IMM ||
                   form == x86_decode_pkg::FORM_MODRM_RM_REG_IMM ||
                   form == x86_decode_pkg::FORM_MODRM_REG_RM_IMM;

  // R/M as operand 0, d bit clear
  assign opnd0_modrm_rm = form == x86_decode_pkg::FORM_MODRM_RM ||
                          form == x86_decode_pkg::FORM_MODRM_RM_IMM ||
                          form == x86_decode_pkg::FORM_MODRM_RM_REG ||
                          form == x86_decode_pkg::FORM_MODRM_RM_REG_IMM ||
                          form == x86_decode_pkg::FORM_MODRM_RM_REG_CL;
  // REG as operand 0, d bit set
  assign opnd0_modrm_reg = form == x86_decode_pkg::FORM_MODRM_REG_RM ||
                           form == x86_decode_pkg::FORM_MODRM_REG_RM_IMM;
  assign opnd1_modrm_rm  = opnd0_modrm_reg;
  assign opnd1_modrm_reg = form == x86_decode_pkg::FORM_MODRM_RM_REG ||
                           form == x86_decode_pkg::FORM_MODRM_RM_REG_IMM ||
                           form == x86_decode_pkg::FORM_MODRM_RM_REG_CL;
  assign has_modrm       = opnd0_modrm_rm || opnd0_modrm_reg;
  assign opnd0_opcode    = form == x86_decode_pkg::FORM_REG || form == x86_decode_pkg::FORM_REG_IMM;
  assign opnd0_eax       = form == x86_decode_pkg::FORM_EAX_IMM || form == x86_decode_pkg::FORM_EAX_REG;

  assign byte1     = instr[15:8];
  assign modrm     = byte1.modrm;
  assign rm_direct = modrm.mod == 2'b11;

  // SIB only with 32-bit addressing, memory mode and rm 100
  assign has_sib    = has_modrm && !stage.prefixes.address_16 && !rm_direct && modrm.rm == 3'b100;
  assign disp_1byte = has_modrm && modrm.mod == 2'b01;
  assign disp_4byte = has_modrm && (modrm.mod == 2'b10 || (modrm.mod == 2'b00 && modrm.rm == 3'b101));

  // Immediate follows opcode, ModR/M, SIB and displacement
  assign imm_off   = 3'd2 + {2'b0, has_sib} + (disp_1byte ? 3'd1 : 3'd0) +
                     (disp_4byte ? 3'd4 : 3'd0);
  assign imm_shift = instr >> {imm_off, 3'b000};
  // Without ModR/M the immediate starts right at byte 1
  assign imm_window = has_modrm ? imm_shift[31:0] : {instr[39:16], byte1.imm8};

  always_comb begin
    if (stage.entry.imm_1byte) begin
      imm = {{24{imm_window[7]}}, imm_window[7:0]};
    end else if (stage.prefixes.operand_16) begin
      imm = {{16{imm_window[15]}}, imm_window[15:0]};
    end else begin
      imm = imm_window;
    end
  end

  // Register selectors
  always_comb begin
    if (opnd0_opcode) sel0 = instr[2:0];
    else if (opnd0_modrm_rm) sel0 = modrm.rm;
    else if (opnd0_modrm_reg) sel0 = modrm.regop;
    else sel0 = x86_decode_pkg::REG_EAX;
    if (opnd1_modrm_rm) sel1 = modrm.rm;
    else if (opnd1_modrm_reg) sel1 = modrm.regop;
    else sel1 = instr[2:0];
  end

  always_comb begin
    kind0 = x86_decode_pkg::KIND_NONE;
    kind1 = x86_decode_pkg::KIND_NONE;
    kind2 = x86_decode_pkg::KIND_NONE;
    if (opnd0_opcode || opnd0_eax || opnd0_modrm_reg) kind0 = x86_decode_pkg::KIND_REG;
    else if (opnd0_modrm_rm) kind0 = rm_direct ? x86_decode_pkg::KIND_REG : x86_decode_pkg::KIND_MEM;
    if (opnd1_modrm_rm) kind1 = rm_direct ? x86_decode_pkg::KIND_REG : x86_decode_pkg::KIND_MEM;
    else if (opnd1_modrm_reg || form == x86_decode_pkg::FORM_EAX_REG) kind1 = x86_decode_pkg::KIND_REG;
    // Implicit CL shift count
    if (form == x86_decode_pkg::FORM_MODRM_RM_REG_CL) kind2 = x86_decode_pkg::KIND_REG;
    // Immediate takes the first free slot
    if (has_imm) begin
      if (kind0 == x86_decode_pkg::KIND_NONE) kind0 = x86_decode_pkg::KIND_IMM;
      else if (kind1 == x86_decode_pkg::KIND_NONE) kind1 = x86_decode_pkg::KIND_IMM;
      else kind2 = x86_decode_pkg::KIND_IMM;
    end
  end

  assign result.opc        = stage.entry.opc;
  assign result.has_sib    = has_sib;
  assign result.disp_1byte = disp_1byte;
  assign result.disp_4byte = disp_4byte;
  assign result.kind0      = kind0;
  assign result.kind1      = kind1;
  assign result.kind2      = kind2;
  assign result.opnd0 = pick(kind0, size_reg(regs[sel0], stage.entry.reg_1byte,
                                             stage.prefixes.operand_16), imm);
  assign result.opnd1 = pick(kind1, size_reg(regs[sel1], stage.entry.reg_1byte,
                                             stage.prefixes.operand_16), imm);
  // CL is always the low byte of ECX
  assign result.opnd2 = pick(kind2, {24'd0, regs[x86_decode_pkg::REG_ECX][7:0]}, imm);
  assign result.opnd_count = 2'(kind0 != x86_decode_pkg::KIND_NONE) +
                             2'(kind1 != x86_decode_pkg::KIND_NONE) +
                             2'(kind2 != x86_decode_pkg::KIND_NONE);

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_config.svh"

module gpr_file (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     wr_en,
  input  wire x86_decode_pkg::reg_sel_e wr_sel,
  input  wire logic [31:0]              wr_data,
  output x86_decode_pkg::gpr_bank_t     bank
);

  // Index 0 is EAX, matching the register numbers
  logic [`X86_NUM_REGS-1:0][31:0] regs;

  // Single write port, new value visible from the next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Whole bank goes out flat for combinational reads
  assign bank = regs;

endmodule

`default_nettype wire

/* logic/opcode_table.sv */
`timescale 1ns/1ps
`default_nettype none

module opcode_table (
  input  wire logic [7:0]           opcode,
  output x86_decode_pkg::op_entry_t entry
);

  // Operation classes
  localparam logic [5:0] OPC_NONE = 6'd0;
  localparam logic [5:0] OPC_ADD  = 6'd1;
  localparam logic [5:0] OPC_OR   = 6'd2;
  localparam logic [5:0] OPC_AND  = 6'd3;
  localparam logic [5:0] OPC_SUB  = 6'd4;
  localparam logic [5:0] OPC_XOR  = 6'd5;
  localparam logic [5:0] OPC_CMP  = 6'd6;
  localparam logic [5:0] OPC_INC  = 6'd7;
  localparam logic [5:0] OPC_DEC  = 6'd8;
  localparam logic [5:0] OPC_MOV  = 6'd9;
  localparam logic [5:0] OPC_XCHG = 6'd10;
  localparam logic [5:0] OPC_IMUL = 6'd11;
  localparam logic [5:0] OPC_GRP1 = 6'd12;
  localparam logic [5:0] OPC_SHLD = 6'd13;
  localparam logic [5:0] OPC_PUSH = 6'd14;

  logic [5:0] alu_class;
  logic       alu_grp;

  // Bits 5:3 pick the ALU op in the 00-3D block, ADC and SBB left out
  always_comb begin
    case (opcode[5:3])
      3'd0:    alu_class = OPC_ADD;
      3'd1:    alu_class = OPC_OR;
      3'd4:    alu_class = OPC_AND;
      3'd5:    alu_class = OPC_SUB;
      3'd6:    alu_class = OPC_XOR;
      3'd7:    alu_class = OPC_CMP;
      default: alu_class = OPC_NONE;
    endcase
  end

  // Low 3 bits 6 and 7 are segment push/pop and BCD ops
  assign alu_grp = (opcode[7:6] == 2'b00) && (opcode[2:1] != 2'b11) && (alu_class != OPC_NONE);

  always_comb begin
    entry.opc       = OPC_NONE;
    entry.form      = x86_decode_pkg::FORM_NONE;
    entry.imm_1byte = 1'b0;
    entry.reg_1byte = 1'b0;
    entry.known     = 1'b0;
    if (alu_grp) begin
      entry.opc       = alu_class;
      entry.known     = 1'b1;
      // Bit 0 clear selects the byte-sized variant
      entry.reg_1byte = ~opcode[0];
      case (opcode[2:1])
        2'b00:   entry.form = x86_decode_pkg::FORM_MODRM_RM_REG;
        2'b01:   entry.form = x86_decode_pkg::FORM_MODRM_REG_RM;
        default: begin
          entry.form      = x86_decode_pkg::FORM_EAX_IMM;
          entry.imm_1byte = ~opcode[0];
        end
      endcase
    end else begin
      entry.known = 1'b1;
      casez (opcode)
        8'b0100_0???: begin
          entry.opc  = OPC_INC;
          entry.form = x86_decode_pkg::FORM_REG;
        end
        8'b0100_1???: begin
          entry.opc  = OPC_DEC;
          entry.form = x86_decode_pkg::FORM_REG;
        end
        // MOV r8,imm8 then MOV r32,imm32
        8'b1011_????: begin
          entry.opc       = OPC_MOV;
          entry.form      = x86_decode_pkg::FORM_REG_IMM;
          entry.imm_1byte = ~opcode[3];
          entry.reg_1byte = ~opcode[3];
        end
        8'h69, 8'h6b: begin
          entry.opc       = OPC_IMUL;
          entry.form      = x86_decode_pkg::FORM_MODRM_REG_RM_IMM;
          entry.imm_1byte = opcode[1];
        end
        8'h80, 8'h81, 8'h83: begin
          entry.opc       = OPC_GRP1;
          entry.form      = x86_decode_pkg::FORM_MODRM_RM_IMM;
          entry.imm_1byte = opcode != 8'h81;
          entry.reg_1byte = opcode == 8'h80;
        end
        // Single-byte stand-in for SHLD r/m32,r32,CL
        8'hd3: begin
          entry.opc  = OPC_SHLD;
          entry.form = x86_decode_pkg::FORM_MODRM_RM_REG_CL;
        end
        8'h68, 8'h6a: begin
          entry.opc       = OPC_PUSH;
          entry.form      = x86_decode_pkg::FORM_IMM;
          entry.imm_1byte = opcode[1];
        end
        default: begin
          // 90 is NOP, 91-97 exchange with EAX
          if (opcode[7:3] == 5'b10010 && opcode[2:0] != 3'd0) begin
            entry.opc  = OPC_XCHG;
            entry.form = x86_decode_pkg::FORM_EAX_REG;
          end else begin
            entry.known = 1'b0;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/prefix_strip.sv */
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_config.svh"

module prefix_strip (
  input  wire logic [`X86_RAW_W-1:0]  raw,
  output logic [`X86_RAW_W-17:0]      unescaped,
  output x86_decode_pkg::prefix_t     prefixes
);

  logic [7:0] byte0;
  logic [7:0] byte1;
  logic       pfx0;
  logic       pfx1;

  assign byte0 = raw[7:0];
  assign byte1 = raw[15:8];

  // Only operand size and address size prefixes are recognised
  assign pfx0 = (byte0 == 8'h66) || (byte0 == 8'h67);
  // A second prefix only counts behind a first one
  assign pfx1 = pfx0 && ((byte1 == 8'h66) || (byte1 == 8'h67));

  // Shift past the prefix bytes, top bytes become don't-care tail
  always_comb begin
    if (pfx1) begin
      unescaped = raw[`X86_RAW_W-1:16];
    end else if (pfx0) begin
      unescaped = raw[`X86_RAW_W-9:8];
    end else begin
      unescaped = raw[`X86_RAW_W-17:0];
    end
  end

  // Either position may carry either prefix, repeats collapse to one flag
  assign prefixes.operand_16 = (pfx0 && byte0 == 8'h66) || (pfx1 && byte1 == 8'h66);
  assign prefixes.address_16 = (pfx0 && byte0 == 8'h67) || (pfx1 && byte1 == 8'h67);

endmodule

`default_nettype wire

/* logic/x86_decode_config.svh */
`ifndef X86_DECODE_CONFIG_SVH
`define X86_DECODE_CONFIG_SVH

// Raw instruction word, two prefix bytes plus nine body bytes
`define X86_RAW_W 88

// General registers in the bank
`define X86_NUM_REGS 8

// Cycles from instr_valid to out_valid
`define X86_LATENCY 2

`endif

/* logic/x86_decode_pkg.sv */
`default_nettype none

`include "x86_decode_config.svh"

package x86_decode_pkg;

  // Operand encoding of an opcode
  typedef enum logic [3:0] {
    FORM_NONE,
    FORM_REG,
    FORM_REG_IMM,
    FORM_IMM,
    FORM_EAX_IMM,
    FORM_EAX_REG,
    FORM_MODRM_RM,
    FORM_MODRM_RM_IMM,
    FORM_MODRM_RM_REG,
    FORM_MODRM_RM_REG_IMM,
    FORM_MODRM_RM_REG_CL,
    FORM_MODRM_REG_RM,
    FORM_MODRM_REG_RM_IMM
  } opnd_form_e;

  typedef enum logic [1:0] {KIND_NONE, KIND_REG, KIND_IMM, KIND_MEM} opnd_kind_e;

  // x86 register numbering
  typedef enum logic [2:0] {
    REG_EAX, REG_ECX, REG_EDX, REG_EBX, REG_ESP, REG_EBP, REG_ESI, REG_EDI
  } reg_sel_e;

  typedef struct packed {logic [1:0] mod; logic [2:0] regop; logic [2:0] rm;} modrm_t;

  typedef struct packed {logic [1:0] scale; logic [2:0] index; logic [2:0] base;} sib_t;

  // Byte 1 is ModR/M or the start of an immediate, depending on the form
  typedef union packed {modrm_t modrm; logic [7:0] imm8;} modrm_imm_u;

  typedef struct packed {logic operand_16; logic address_16;} prefix_t;

  typedef struct packed {
    logic [5:0] opc;
    opnd_form_e form;
    logic       imm_1byte;
    logic       reg_1byte;
    logic       known;
  } op_entry_t;

  typedef struct packed {
    logic [`X86_RAW_W-17:0] unescaped;
    prefix_t                prefixes;
    op_entry_t              entry;
  } stage1_t;

  // EAX in the low word so the bank indexes by register number
  typedef struct packed {
    logic [31:0] edi, esi, ebp, esp, ebx, edx, ecx, eax;
  } gpr_bank_t;

  typedef struct packed {
    logic [5:0]  opc;
    logic [1:0]  opnd_count;
    logic        has_sib;
    logic        disp_1byte;
    logic        disp_4byte;
    logic [31:0] opnd0, opnd1, opnd2;
    opnd_kind_e  kind0, kind1, kind2;
  } opnd_result_t;

endpackage

`default_nettype wire

/* logic/x86_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_config.svh"

module x86_decode_top (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     instr_valid,
  input  wire logic [`X86_RAW_W-1:0]    instr,
  input  wire logic                     wr_en,
  input  wire x86_decode_pkg::reg_sel_e wr_sel,
  input  wire logic [31:0]              wr_data,
  output logic                          out_valid,
  output x86_decode_pkg::opnd_result_t  result
);

  logic [`X86_RAW_W-17:0]       unescaped;
  logic [`X86_LATENCY-1:0]      valid_pipe;
  x86_decode_pkg::prefix_t      prefixes;
  x86_decode_pkg::op_entry_t    entry;
  x86_decode_pkg::stage1_t      stage;
  x86_decode_pkg::gpr_bank_t    bank;
  x86_decode_pkg::opnd_result_t result_d;

  prefix_strip u_prefix_strip (.raw(instr), .unescaped(unescaped), .prefixes(prefixes));

  // Opcode sits in byte 0 once prefixes are gone
  opcode_table u_opcode_table (.opcode(unescaped[7:0]), .entry(entry));

  gpr_file u_gpr_file (
    .clk(clk), .rst(rst), .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data), .bank(bank)
  );

  decode_opnds u_decode_opnds (.stage(stage), .bank(bank), .result(result_d));

  // Stage one then the result register, one instruction per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
      stage      <= '0;
      result     <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`X86_LATENCY-2:0], instr_valid};
      if (instr_valid) stage <= '{unescaped: unescaped, prefixes: prefixes, entry: entry};
      // Result holds until the next valid instruction replaces it
      if (valid_pipe[0]) result <= result_d;
    end
  end

  assign out_valid = valid_pipe[`X86_LATENCY-1];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module x86_decode_tb -o x86_decode_sim

./obj_dir/x86_decode_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
echo "Simulation reported failures, see sim.log"
exit 1

/* verification/x86_decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_config.svh"

module x86_decode_tb;

  localparam int RESET_CYCLES = 16;
  localparam int MARGIN       = 200;
  // Opcodes cycled through by the random ModR/M section
  localparam logic [63:0] RANDOM_OPS = 64'h01_03_31_81_83_6b_69_d3;

  logic                         clk;
  logic                         rst;
  logic                         instr_valid;
  logic [`X86_RAW_W-1:0]        instr;
  logic                         wr_en;
  x86_decode_pkg::reg_sel_e     wr_sel;
  logic [31:0]                  wr_data;
  logic                         out_valid;
  x86_decode_pkg::opnd_result_t result;

  // Testbench copy of the register bank
  logic [31:0] model_regs [8];
  // Expected results in issue order
  x86_decode_pkg::opnd_result_t want_q [$];
  string                        name_q [$];
  x86_decode_pkg::opnd_result_t want;
  x86_decode_pkg::opnd_result_t got;
  string  tname;
  integer seed = 32'hb221;
  int     errors = 0;
  int     checks = 0;
  int     issued = 0;
  int     cycles = 0;
  int     k;

  x86_decode_top DUT (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .wr_en(wr_en),
    .wr_sel(wr_sel), .wr_data(wr_data), .out_valid(out_valid), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Result strobe trails the input strobe by the pipeline depth
  assert property (@(posedge clk) disable iff (rst) out_valid == $past(instr_valid, `X86_LATENCY))
    else begin
      errors++;
      $display("out_valid did not follow instr_valid by %0d cycles", `X86_LATENCY);
    end

  // Nothing valid and an all-zero bank while reset holds
  assert property (@(posedge clk) rst |=> (!out_valid && DUT.bank == '0))
    else begin
      errors++;
      $display("out_valid high or a register nonzero during reset");
    end

  function automatic logic [31:0] width_masked(input logic [31:0] v, input logic byte_op,
                                               input logic op16);
    if (byte_op) return v & 32'h0000_00ff;
    if (op16) return v & 32'h0000_ffff;
    return v;
  endfunction

  // Expected decode of a raw word, from the x86 encoding rules
  function automatic x86_decode_pkg::opnd_result_t expect_result(input logic [87:0] raw);
    x86_decode_pkg::opnd_result_t r;
    x86_decode_pkg::opnd_kind_e   kinds [3];
    logic [31:0] vals [3];
    logic [7:0]  b [9];
    logic [23:0] slots;
    logic [7:0]  slot;
    logic [31:0] imm;
    logic [5:0]  cls;
    logic [1:0]  mdd;
    logic [2:0]  rg;
    logic [2:0]  rm;
    logic op16, a16, byte_op, imm1, has_m;
    int   i, npfx, pos, len, cnt;
    npfx = 0;
    op16 = 1'b0;
    a16  = 1'b0;
    // Up to two size prefixes in either order, repeats count once
    for (i = 0; i < 2; i++) begin
      if (npfx == i && (raw[8*i +: 8] == 8'h66 || raw[8*i +: 8] == 8'h67)) begin
        op16 |= raw[8*i +: 8] == 8'h66;
        a16  |= raw[8*i +: 8] == 8'h67;
        npfx++;
      end
    end
    for (i = 0; i < 9; i++) b[i] = raw[8*(npfx+i) +: 8];
    mdd = b[1][7:6];
    rg  = b[1][5:3];
    rm  = b[1][2:0];
    byte_op = 1'b0;
    imm1    = 1'b0;
    // Operation class counts up from ADD in table order, zero when unknown
    cls     = 6'd0;
    // Slot letters: O opcode reg, A EAX, R ModR/M reg, M r/m, I immediate, C CL
    slots = "---";
    if (b[0] < 8'h40 && b[0][2:0] < 3'd6 && b[0][5:3] != 3'd2 && b[0][5:3] != 3'd3) begin
      byte_op = !b[0][0];
      case (b[0][5:3])
        3'd0:    cls = 6'd1;
        3'd1:    cls = 6'd2;
        3'd4:    cls = 6'd3;
        3'd5:    cls = 6'd4;
        3'd6:    cls = 6'd5;
        default: cls = 6'd6;
      endcase
      case (b[0][2:1])
        2'd0:    slots = "MR-";
        2'd1:    slots = "RM-";
        default: begin
          slots = "AI-";
          imm1  = !b[0][0];
        end
      endcase
    end else if (b[0][7:4] == 4'h4) begin
      slots = "O--";
      cls   = b[0][3] ? 6'd8 : 6'd7;
    end else if (b[0][7:4] == 4'hb) begin
      slots   = "OI-";
      cls     = 6'd9;
      byte_op = !b[0][3];
      imm1    = !b[0][3];
    end else begin
      case (b[0])
        8'h69, 8'h6b: begin
          slots = "RMI";
          cls   = 6'd11;
          imm1  = b[0] == 8'h6b;
        end
        8'h80, 8'h81, 8'h83: begin
          slots   = "MI-";
          cls     = 6'd12;
          imm1    = b[0] != 8'h81;
          byte_op = b[0] == 8'h80;
        end
        8'hd3: begin
          slots = "MRC";
          cls   = 6'd13;
        end
        8'h68, 8'h6a: begin
          slots = "I--";
          cls   = 6'd14;
          imm1  = b[0] == 8'h6a;
        end
        8'h91, 8'h92, 8'h93, 8'h94, 8'h95, 8'h96, 8'h97: begin
          slots = "AO-";
          cls   = 6'd10;
        end
        default: slots = "---";
      endcase
    end
    has_m = slots[23:16] == "M" || slots[15:8] == "M";
    r = '0;
    r.opc = cls;
    if (has_m) begin
      r.has_sib    = !a16 && mdd != 2'b11 && rm == 3'd4;
      r.disp_1byte = mdd == 2'b01;
      r.disp_4byte = mdd == 2'b10 || (mdd == 2'b00 && rm == 3'd5);
    end
    // Immediate sits after opcode, ModR/M, SIB and displacement
    pos = 1 + (has_m ? 1 : 0) + (r.has_sib ? 1 : 0) + (r.disp_1byte ? 1 : 0) +
          (r.disp_4byte ? 4 : 0);
    len = imm1 ? 1 : (op16 ? 2 : 4);
    imm = '0;
    for (i = 0; i < len; i++) begin
      if (pos + i < 9) imm[8*i +: 8] = b[pos+i];
    end
    if (len == 1) imm = {{24{imm[7]}}, imm[7:0]};
    else if (len == 2) imm = {{16{imm[15]}}, imm[15:0]};
    cnt = 0;
    for (i = 0; i < 3; i++) begin
      slot     = slots[23-8*i -: 8];
      kinds[i] = x86_decode_pkg::KIND_REG;
      vals[i]  = '0;
      case (slot)
        "O": vals[i] = width_masked(model_regs[b[0][2:0]], byte_op, op16);
        "A": vals[i] = width_masked(model_regs[0], byte_op, op16);
        "R": vals[i] = width_masked(model_regs[rg], byte_op, op16);
        "M": begin
          if (mdd == 2'b11) vals[i] = width_masked(model_regs[rm], byte_op, op16);
          else kinds[i] = x86_decode_pkg::KIND_MEM;
        end
        "I": begin
          kinds[i] = x86_decode_pkg::KIND_IMM;
          vals[i]  = imm;
        end
        "C": vals[i] = {24'd0, model_regs[1][7:0]};
        default: kinds[i] = x86_decode_pkg::KIND_NONE;
      endcase
      if (kinds[i] != x86_decode_pkg::KIND_NONE) cnt++;
    end
    r.opnd_count = 2'(cnt);
    r.opnd0 = vals[0];
    r.opnd1 = vals[1];
    r.opnd2 = vals[2];
    r.kind0 = kinds[0];
    r.kind1 = kinds[1];
    r.kind2 = kinds[2];
    return r;
  endfunction

  task automatic write_reg(input logic [2:0] sel, input logic [31:0] data);
    wr_en   = 1'b1;
    wr_sel  = x86_decode_pkg::reg_sel_e'(sel);
    wr_data = data;
    model_regs[sel] = data;
    @(posedge clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic fill_regs_random();
    int i;
    for (i = 0; i < 8; i++) write_reg(3'(i), $random(seed));
  endtask

  // First byte of the instruction is the top byte of the low n bytes
  task automatic send(input string name, input int n, input logic [87:0] bytes);
    logic [87:0] raw;
    int i;
    for (i = 0; i < 11; i++) begin
      raw[8*i +: 8] = (i < n) ? bytes[8*(n-1-i) +: 8] : 8'($random(seed));
    end
    instr       = raw;
    instr_valid = 1'b1;
    want_q.push_back(expect_result(raw));
    name_q.push_back(name);
    issued++;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  // Compare mid-cycle, away from the result register update
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (want_q.size() == 0) begin
        errors++;
        $display("A result appeared with no instruction pending");
      end else begin
        want  = want_q.pop_front();
        tname = name_q.pop_front();
        got   = result;
        checks++;
        assert (got == want)
          else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", tname, want, got);
          end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > RESET_CYCLES + 8 * issued + MARGIN) begin
      $display("Timeout after %0d cycles with %0d results pending", cycles, want_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    wr_en       = 1'b0;
    wr_sel      = x86_decode_pkg::REG_EAX;
    wr_data     = '0;
    for (k = 0; k < 8; k++) model_regs[k] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register-direct forms, back to back
    fill_regs_random();
    send("add_rm_reg", 2, 88'h01_c8);
    send("add_reg_rm", 2, 88'h03_d3);
    send("xor_rm_reg", 2, 88'h31_f7);
    send("xor_reg_rm", 2, 88'h33_c6);
    send("add_rm_reg_8", 2, 88'h00_d9);
    // Write seen only by the instruction issued after it commits
    write_reg(3'd2, 32'h8000_0001);
    send("add_after_write", 2, 88'h01_d0);
    write_reg(3'd2, 32'h1234_5678);
    send("add_sees_write", 2, 88'h01_d0);

    // Immediates and operand size
    send("mov_ecx_imm32", 5, 88'hb9_78_56_34_12);
    send("mov_dl_imm8", 2, 88'hb2_f0);
    send("add_imm8_sext", 3, 88'h83_c1_80);
    send("imul_imm8", 3, 88'h6b_c2_fe);
    send("imul_imm32", 6, 88'h69_da_44_33_22_11);
    send("add_ax_imm16", 4, 88'h66_05_34_f2);
    send("grp1_imm16", 5, 88'h66_81_c3_00_80);
    send("add_rm_reg_16", 3, 88'h66_01_d8);
    send("mov_bx_imm16", 4, 88'h66_bb_ff_7f);
    send("push_imm32", 5, 88'h68_ef_be_ad_de);
    send("push_imm8", 2, 88'h6a_9c);
    send("double_66", 5, 88'h66_66_05_80_00);

    // Implicit EAX and CL
    send("xchg_eax_ebx", 1, 88'h93);
    send("xchg_eax_ebp_16", 2, 88'h66_95);
    send("add_eax_imm32", 5, 88'h05_01_00_00_80);
    send("or_al_imm8", 2, 88'h0c_7f);
    send("shld_cl_reg", 2, 88'hd3_e0);
    send("shld_cl_mem", 3, 88'hd3_45_10);

    // Memory forms, SIB and displacement lengths
    send("sib_mod00", 3, 88'h01_04_24);
    send("disp32_mod00", 6, 88'h01_05_00_10_00_00);
    send("sib_disp8_imm8", 5, 88'h83_44_24_08_05);
    send("sib_disp32_imm8", 8, 88'h83_84_24_00_01_00_00_f7);
    send("disp8_rm101_imm32", 7, 88'h81_45_08_11_22_33_44);
    send("disp32_rm101_imm8", 7, 88'h83_85_00_02_00_00_81);
    send("reg_rm_mem", 4, 88'h03_4c_24_08);
    send("imul_mem_imm8", 5, 88'h6b_44_24_04_03);
    send("a16_no_sib", 5, 88'h67_83_44_10_7f);
    send("a16_mod00_rm100", 4, 88'h67_83_04_7f);
    send("o16_a16_disp32", 10, 88'h66_67_81_05_00_00_01_00_34_12);
    send("a16_o16_order", 5, 88'h67_66_83_c0_05);

    // Opcodes outside the table
    send("unknown_0f", 2, 88'h0f_af);
    send("unknown_adc", 2, 88'h10_c0);
    send("unknown_daa", 1, 88'h27);
    send("unknown_nop", 1, 88'h90);
    send("unknown_hlt", 1, 88'hf4);

    // Known opcodes with random ModR/M and trailing bytes
    fill_regs_random();
    for (k = 0; k < 16; k++) begin
      send("random_modrm", 1, {80'd0, RANDOM_OPS[8*(k%8) +: 8]});
    end
    for (k = 0; k < 8; k++) begin
      send("random_modrm_16", 2, {72'd0, 8'h66, RANDOM_OPS[8*k +: 8]});
    end

    while (want_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("Summary: %0d results checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
